//--- all.f
source/uart_frame_pkg.sv
source/uart_cmd_pkg.sv
source/tx_byte_if.sv
source/uart_tx_frame.sv
source/uart_rx_frame.sv
source/uart_cmd_ctrl.sv
source/uart_cmd_top.sv
bench/uart_cmd_tb.sv

//--- bench/uart_cmd_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_tb
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
();

  localparam int N_CMDS          = 32;
  localparam int MAX_REPLY_DELAY = 200;
  localparam int TIMEOUT_CYCLES  =
    N_CMDS * (2 * FRAME_BITS * BAUD_DIV + GAP_CYCLES + MAX_REPLY_DELAY) * 2;

  typedef struct packed {
    uart_byte_t  data;
    logic        par_ok;
    logic        framing_ok;  // start low and stop high
    int unsigned start_cyc;
  } frame_t;

  typedef struct packed {
    uart_byte_t data;
    logic       err;
  } reply_t;

  logic                 clk;
  logic                 rst_n;
  logic [CMD_WIDTH-1:0] cmd_in;
  logic                 cmd_vld;
  logic                 cmd_rdy;
  logic                 rx;
  logic                 tx;
  uart_byte_t           read_data;
  logic                 read_rdy;
  logic                 read_err;

  uart_cmd_t   cmds[N_CMDS];
  uart_byte_t  reply_byte[N_CMDS];
  int unsigned reply_delay[N_CMDS];
  frame_t      obs_q[$];
  reply_t      rd_q[$];
  int          errors = 0;
  int          tests_run = 0;
  int          tests_passed = 0;
  int unsigned cyc;

  uart_cmd_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // parity bit that makes the frame's count of ones odd
  function automatic logic parity_for(input uart_byte_t b);
    int n;
    n = 0;
    for (int k = 0; k < DATA_BITS; k++)
      n += b[k];
    return (n % 2 == 0);
  endfunction

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (exp !== act)
    begin
      $display("Fail at %0t: %s expected %02h got %02h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_read(input uart_byte_t exp_data, input logic exp_err,
                            input uart_byte_t act_data, input logic act_err);
    check_byte("read_data", exp_data, act_data);
    check_bit("read_err", exp_err, act_err);
  endtask

  task automatic check_frame(input string name, input uart_byte_t exp, input frame_t f);
    check_byte(name, exp, f.data);
    check_bit("tx parity ok", 1'b1, f.par_ok);
    check_bit("tx start/stop ok", 1'b1, f.framing_ok);
  endtask

  task automatic finish_test(input string desc, input int err_before);
    tests_run++;
    if (errors == err_before)
    begin
      tests_passed++;
      $display("test %0d %s: pass", tests_run, desc);
    end
    else
      $display("test %0d %s: FAIL", tests_run, desc);
  endtask

  task automatic next_frame(output frame_t f);
    while (obs_q.size() == 0)
      @(negedge clk);
    f = obs_q.pop_front();
  endtask

  // serial reply on rx, called 1 ns after a rising edge
  task automatic drive_rx_frame(input uart_byte_t b, input logic bad);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, parity_for(b) ^ bad, b, 1'b0};
    for (int k = 0; k < FRAME_BITS; k++)
    begin
      rx = bits[k];
      repeat (BAUD_DIV) @(posedge clk);
      #1;
    end
  endtask

  // host side, next command waits with cmd_vld high while cmd_rdy is low
  task automatic drive_cmds();
    for (int i = 0; i < N_CMDS; i++)
    begin
      cmd_in  = cmds[i];
      cmd_vld = 1'b1;
      do
        @(negedge clk);
      while (cmd_rdy !== 1'b1);
      @(posedge clk);  // accepted here
      #1;
    end
    cmd_vld = 1'b0;
  endtask

  task automatic run_checks();
    frame_t    f0;
    frame_t    f1;
    reply_t    r;
    uart_cmd_t c;
    int        err_before;
    int        gap;
    int        rd_count;
    logic      bad;
    rd_count = 0;
    for (int i = 0; i < N_CMDS; i++)
    begin
      c = cmds[i];
      err_before = errors;
      if (c.wr)
      begin
        next_frame(f0);
        check_frame("tx low byte", c.lo_byte, f0);
        next_frame(f1);
        check_frame("tx high byte", c[CMD_WIDTH-1:DATA_BITS], f1);
        gap = f1.start_cyc - f0.start_cyc - FRAME_BITS * BAUD_DIV;
        if (gap < GAP_CYCLES)
        begin
          $display("Gap between write frames was %0d cycles, less than %0d", gap, GAP_CYCLES);
          errors++;
        end
        finish_test($sformatf("write %04h", c), err_before);
      end
      else
      begin
        next_frame(f0);
        check_frame("tx address byte", c[CMD_WIDTH-1:DATA_BITS], f0);
        bad = (rd_count % 4 == 3);  // every fourth reply corrupted
        repeat (reply_delay[i] + 1) @(posedge clk);
        #1;
        drive_rx_frame(reply_byte[i], bad);
        while (rd_q.size() == 0)
          @(negedge clk);
        r = rd_q.pop_front();
        check_read(reply_byte[i], bad, r.data, r.err);
        rd_count++;
        finish_test($sformatf("read %04h reply %02h bad parity %b", c, reply_byte[i], bad),
                    err_before);
      end
    end
  endtask

  // line model, samples tx at mid-bit
  initial
  begin
    frame_t f;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge tx);
      f.start_cyc = cyc;
      repeat (BAUD_DIV/2) @(negedge clk);
      f.framing_ok = (tx === 1'b0);
      for (int b = 0; b < DATA_BITS; b++)
      begin
        repeat (BAUD_DIV) @(negedge clk);
        f.data[b] = tx;
      end
      repeat (BAUD_DIV) @(negedge clk);
      f.par_ok = (parity_for(f.data) === tx);
      repeat (BAUD_DIV) @(negedge clk);
      f.framing_ok = f.framing_ok && (tx === 1'b1);
      obs_q.push_back(f);
    end
  end

  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
      rd_q.push_back({read_data, read_err});
  end

  initial
  begin
    cyc = 0;
    while (cyc < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    int          err_before;
    int unsigned seed;
    int unsigned rnd;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    seed    = 32'h8564_15b1;
    void'($urandom(seed));
    for (int i = 0; i < N_CMDS; i++)
    begin
      rnd     = $urandom;
      cmds[i] = rnd[CMD_WIDTH-1:0];
      if (i % 4 == 1)
        cmds[i].wr = 1'b0;  // keep enough reads in the mix
      if (i % 4 == 2)
        cmds[i].wr = 1'b1;
      rnd            = $urandom;
      reply_byte[i]  = rnd[DATA_BITS-1:0];
      reply_delay[i] = $urandom_range(MAX_REPLY_DELAY);
    end

    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    err_before = errors;
    repeat (4)
    begin
      @(negedge clk);
      check_bit("tx", 1'b1, tx);
      check_bit("cmd_rdy", 1'b1, cmd_rdy);
      check_bit("read_rdy", 1'b0, read_rdy);
      check_bit("read_err", 1'b0, read_err);
    end
    finish_test("reset state", err_before);

    @(posedge clk);
    #1;
    fork
      drive_cmds();
      run_checks();
    join

    err_before = errors;
    repeat (2 * FRAME_BITS * BAUD_DIV) @(negedge clk);
    if (obs_q.size() != 0)
    begin
      $display("%0d extra frames appeared on tx", obs_q.size());
      errors++;
    end
    if (rd_q.size() != 0)
    begin
      $display("%0d extra read_rdy pulses appeared", rd_q.size());
      errors++;
    end
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    finish_test("no extra traffic", err_before);

    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/tx_byte_if.sv
`timescale 1ns/100ps
`default_nettype none

interface tx_byte_if
  import uart_frame_pkg::*;
();

  uart_byte_t data;
  logic       send;  // pulse, only while busy low
  logic       busy;
  logic       done;  // pulse on last stop bit cycle

  modport ctrl (output data, output send, input busy, input done);
  modport tx (input data, input send, output busy, output done);

endinterface

`default_nettype wire

//--- source/uart_cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_ctrl
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  tx_byte_if.ctrl    bus,
  input  uart_byte_t rx_byte,
  input  logic       rx_valid,
  input  logic       rx_parity_ok,
  output uart_byte_t read_data,
  output logic       read_rdy,
  output logic       read_err
);

  ctrl_state_t                   state;
  uart_cmd_t                     cmd_q;
  logic [$clog2(GAP_CYCLES)-1:0] gap_cnt;
  logic                          send_q;
  logic                          accept;
  logic                          reply;

  assign cmd_rdy = (state == st_idle);
  assign accept  = cmd_vld && cmd_rdy;
  assign reply   = (state == st_wait_reply) && rx_valid;  // replies elsewhere are dropped

  assign bus.send = send_q;
  // low byte only for the first write frame, else the high byte
  assign bus.data = (state == st_send_lo) ? cmd_q.lo_byte : {cmd_q.wr, cmd_q.hi_rest};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      gap_cnt  <= '0;
      send_q   <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      send_q   <= 1'b0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        st_idle:
        begin
          if (accept)
          begin
            state  <= cmd_in.wr ? st_send_lo : st_send_addr;
            send_q <= 1'b1;
          end
        end
        st_send_lo:
        begin
          if (bus.done)
          begin
            state   <= st_gap;
            gap_cnt <= '0;
          end
        end
        st_gap:
        begin
          // send at count GAP_CYCLES-2 gives exactly GAP_CYCLES idle tx cycles
          if ((gap_cnt == GAP_CYCLES-2) && !bus.busy)
          begin
            state  <= st_send_hi;
            send_q <= 1'b1;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        st_send_hi:
        begin
          if (bus.done)
            state <= st_idle;
        end
        st_send_addr:
        begin
          if (bus.done)
            state <= st_wait_reply;
        end
        st_wait_reply:
        begin
          if (reply)  // no timeout
          begin
            state    <= st_idle;
            read_rdy <= 1'b1;
            read_err <= !rx_parity_ok;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (reply)
      read_data <= rx_byte;
  end

endmodule

`default_nettype wire

//--- source/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  import uart_frame_pkg::*;

  localparam int CMD_WIDTH  = 16;
  localparam int GAP_CYCLES = 100;  // idle cycles between the two write frames

  // bit 15 set means write
  typedef struct packed {
    logic                          wr;
    logic [CMD_WIDTH-DATA_BITS-2:0] hi_rest;  // bits 14..8
    uart_byte_t                    lo_byte;
  } uart_cmd_t;

  typedef enum logic [2:0] {
    st_idle,
    st_send_lo,
    st_gap,
    st_send_hi,
    st_send_addr,
    st_wait_reply
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/uart_cmd_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_top
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [CMD_WIDTH-1:0] cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  input  logic                 rx,
  output logic                 tx,
  output uart_byte_t           read_data,
  output logic                 read_rdy,
  output logic                 read_err
);

  uart_byte_t rx_byte;
  logic       rx_valid;
  logic       rx_parity_ok;

  tx_byte_if tx_bus ();

  uart_cmd_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_in       (uart_cmd_t'(cmd_in)),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .bus          (tx_bus.ctrl),
    .rx_byte      (rx_byte),
    .rx_valid     (rx_valid),
    .rx_parity_ok (rx_parity_ok),
    .read_data    (read_data),
    .read_rdy     (read_rdy),
    .read_err     (read_err)
  );

  uart_tx_frame u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (tx_bus.tx),
    .tx    (tx)
  );

  uart_rx_frame u_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx           (rx),
    .rx_byte      (rx_byte),
    .rx_valid     (rx_valid),
    .rx_parity_ok (rx_parity_ok)
  );

endmodule

`default_nettype wire

//--- source/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

  // clock cycles per serial bit
  // a 50 MHz board at 115200 baud would use 434
  localparam int BAUD_DIV   = 16;
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;   // start, data, parity, stop

  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // odd parity bit: data ones plus parity bit give an odd count
  function automatic logic odd_parity(input uart_byte_t b);
    return ~^b;
  endfunction

endpackage

`default_nettype wire

//--- source/uart_rx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frame
  import uart_frame_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output uart_byte_t rx_byte,
  output logic       rx_valid,
  output logic       rx_parity_ok
);

  logic                          rx_meta;
  logic                          rx_sync;
  logic                          rx_prev;
  logic                          active;
  logic [$clog2(BAUD_DIV)-1:0]   baud_cnt;
  logic [$clog2(FRAME_BITS)-1:0] bit_idx;
  uart_byte_t                    shreg;
  logic                          par_bit;
  logic                          sample;

  // half a period for the start bit, then whole periods
  assign sample = active &&
                  ((bit_idx == 0) ? (baud_cnt == BAUD_DIV/2-1) : (baud_cnt == BAUD_DIV-1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active       <= 1'b0;
      baud_cnt     <= '0;
      bit_idx      <= '0;
      rx_valid     <= 1'b0;
      rx_parity_ok <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (!active)
      begin
        if (rx_prev && !rx_sync)  // falling edge
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        if ((bit_idx == 0) && rx_sync)
          active <= 1'b0;  // glitch, not a start bit
        else if (bit_idx == FRAME_BITS-1)
        begin
          active       <= 1'b0;
          rx_valid     <= 1'b1;
          rx_parity_ok <= (odd_parity(shreg) == par_bit);
        end
        else
          bit_idx <= bit_idx + 1'b1;
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if ((bit_idx >= 1) && (bit_idx <= DATA_BITS))
        shreg <= {rx_sync, shreg[DATA_BITS-1:1]};  // lsb arrives first
      if (bit_idx == DATA_BITS+1)
        par_bit <= rx_sync;
      if (bit_idx == FRAME_BITS-1)
        rx_byte <= shreg;
    end
  end

endmodule

`default_nettype wire

//--- source/uart_tx_frame.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_frame
  import uart_frame_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  tx_byte_if.tx bus,
  output logic tx
);

  logic [$clog2(BAUD_DIV)-1:0]   baud_cnt;
  logic [$clog2(FRAME_BITS)-1:0] bit_idx;
  logic [DATA_BITS+1:0]          shreg;    // data, parity, stop still to go
  logic                          start;
  logic                          bit_end;

  assign start   = bus.send && !bus.busy;
  assign bit_end = bus.busy && (baud_cnt == BAUD_DIV-1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bus.busy <= 1'b0;
      bus.done <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      bus.done <= 1'b0;
      if (start)
      begin
        bus.busy <= 1'b1;
        tx       <= 1'b0;  // start bit
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
      else if (bit_end)
      begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        tx       <= shreg[0];
      end
      else if (bus.busy)
      begin
        baud_cnt <= baud_cnt + 1'b1;
        // free the bus one cycle early so done lands on the last stop cycle
        if ((bit_idx == FRAME_BITS-1) && (baud_cnt == BAUD_DIV-2))
        begin
          bus.busy <= 1'b0;
          bus.done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      shreg <= {1'b1, odd_parity(bus.data), bus.data};
    else if (bit_end)
      shreg <= {1'b1, shreg[DATA_BITS+1:1]};  // lsb first
  end

endmodule

`default_nettype wire
